// File: fx_pkg.sv
package fx_pkg;

    // EEG sample from the ADC
    localparam int ADC_W = 12;

    // Intermediate results and MAC datapath
    localparam int COMP_W = 24;
    localparam int COMP_Q = 18;

    // Kernel and bias storage
    localparam int PARAM_W = 16;
    localparam int PARAM_Q = 14;

    typedef logic signed [COMP_W-1:0] comp_t;
    typedef logic signed [PARAM_W-1:0] param_t;

endpackage

// File: model_pkg.sv
package model_pkg;

    // Patch projection dimensions
    localparam int PATCH_LEN = 8;
    localparam int NUM_PATCHES = 4;
    localparam int EMB_DEPTH = 4;

    localparam int INT_RES_DEPTH = 64;
    localparam int PARAM_DEPTH = 64;

    // Intermediate-result map
    localparam int EEG_BASE = 0;
    localparam int PATCH_OUT_BASE = 32;

    // Parameter map, kernel stored row by row
    localparam int KERNEL_BASE = 0;
    localparam int BIAS_BASE = 32;

    typedef logic [$clog2(INT_RES_DEPTH)-1:0] int_res_addr_t;
    typedef logic [$clog2(PARAM_DEPTH)-1:0] param_addr_t;
    typedef logic [3:0] vec_len_t;

    typedef enum logic [1:0] {
        IDLE_CIM,
        EEG_LOAD,
        INFERENCE_RUNNING
    } cim_state_t;

endpackage

// File: ram_1r1w.sv
`timescale 1ns/1ps

module ram_1r1w
    import fx_pkg::*, model_pkg::*;
#(
    parameter type word_t = comp_t,
    parameter int DEPTH = INT_RES_DEPTH
) (
    input  logic                     clk,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  word_t                    wr_data_i,
    input  logic                     rd_en_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output word_t                    rd_data_o
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        // Registered read, data valid the cycle after the enable
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// File: int_res_bank.sv
`timescale 1ns/1ps

module int_res_bank
    import fx_pkg::*, model_pkg::*;
(
    input  logic          clk,
    input  logic          wr_en_i,
    input  int_res_addr_t wr_addr_i,
    input  comp_t         wr_data_i,
    input  logic          mac_rd_en_i,
    input  int_res_addr_t mac_rd_addr_i,
    input  logic          host_rd_en_i,
    input  int_res_addr_t host_rd_addr_i,
    output comp_t         rd_data_o
);

    logic          rd_en;
    int_res_addr_t rd_addr;

    // MAC has priority, host reads only matter while idle
    always_comb begin
        rd_en = mac_rd_en_i | host_rd_en_i;
        if (mac_rd_en_i) begin
            rd_addr = mac_rd_addr_i;
        end else begin
            rd_addr = host_rd_addr_i;
        end
    end

    ram_1r1w #(
        .word_t(comp_t),
        .DEPTH (INT_RES_DEPTH)
    ) u_mem (
        .clk      (clk),
        .wr_en_i  (wr_en_i),
        .wr_addr_i(wr_addr_i),
        .wr_data_i(wr_data_i),
        .rd_en_i  (rd_en),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data_o)
    );

endmodule

// File: mac_unit.sv
`timescale 1ns/1ps

module mac_unit
    import fx_pkg::*, model_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start_i,
    input  int_res_addr_t data_addr_i,
    input  param_addr_t   kernel_addr_i,
    input  param_addr_t   bias_addr_i,
    input  vec_len_t      len_i,
    output logic          data_rd_en_o,
    output int_res_addr_t data_rd_addr_o,
    input  comp_t         data_i,
    output logic          param_rd_en_o,
    output param_addr_t   param_rd_addr_o,
    input  param_t        param_i,
    output logic          done_o,
    output comp_t         out_o
);

    logic        elem_rd_q;
    logic        bias_rd_q;
    logic        elem_vld_q;
    logic        bias_vld_q;
    logic        prod_vld_q;
    logic        fin_q;
    vec_len_t    cnt_q;
    vec_len_t    len_q;
    param_addr_t bias_addr_q;
    comp_t       param_c;
    comp_t       prod_q;
    comp_t       acc_q;
    comp_t       bias_q;
    logic signed [2*COMP_W-1:0] full_prod;

    assign data_rd_en_o = elem_rd_q;
    assign param_rd_en_o = elem_rd_q | bias_rd_q;

    // Parameter to compute format, then full-width product
    always_comb begin
        param_c = comp_t'(param_i) <<< (COMP_Q - PARAM_Q);
        full_prod = data_i * param_c;
    end

    // Read sequencing and valid pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            elem_rd_q <= 1'b0;
            bias_rd_q <= 1'b0;
            elem_vld_q <= 1'b0;
            bias_vld_q <= 1'b0;
            prod_vld_q <= 1'b0;
            fin_q <= 1'b0;
            done_o <= 1'b0;
            cnt_q <= '0;
        end else begin
            elem_vld_q <= elem_rd_q;
            bias_vld_q <= bias_rd_q;
            prod_vld_q <= elem_vld_q;
            fin_q <= bias_vld_q;
            done_o <= fin_q;
            bias_rd_q <= 1'b0;
            if (start_i) begin
                elem_rd_q <= 1'b1;
                cnt_q <= '0;
            end else if (elem_rd_q) begin
                if (cnt_q == len_q - 1'b1) begin
                    // Last element, bias read follows
                    elem_rd_q <= 1'b0;
                    bias_rd_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            len_q <= len_i;
            bias_addr_q <= bias_addr_i;
            data_rd_addr_o <= data_addr_i;
            param_rd_addr_o <= kernel_addr_i;
            acc_q <= '0;
        end else if (elem_rd_q) begin
            data_rd_addr_o <= data_rd_addr_o + 1'b1;
            if (cnt_q == len_q - 1'b1) begin
                param_rd_addr_o <= bias_addr_q;
            end else begin
                param_rd_addr_o <= param_rd_addr_o + 1'b1;
            end
        end
        // Rescale to COMP_Q, wrap to COMP_W
        if (elem_vld_q) begin
            prod_q <= comp_t'(full_prod >>> COMP_Q);
        end
        if (prod_vld_q) begin
            acc_q <= acc_q + prod_q;
        end
        if (bias_vld_q) begin
            bias_q <= param_c;
        end
        if (fin_q) begin
            out_o <= acc_q + bias_q;
        end
    end

endmodule

// File: cim_ctrl.sv
`timescale 1ns/1ps

module cim_ctrl
    import fx_pkg::*, model_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_eeg_load_i,
    input  logic             new_eeg_data_i,
    input  logic [ADC_W-1:0] eeg_i,
    input  logic             new_sleep_epoch_i,
    output logic             wr_en_o,
    output int_res_addr_t    wr_addr_o,
    output comp_t            wr_data_o,
    output logic             mac_start_o,
    output int_res_addr_t    mac_data_addr_o,
    output param_addr_t      mac_kernel_addr_o,
    output param_addr_t      mac_bias_addr_o,
    output vec_len_t         mac_len_o,
    input  logic             mac_done_i,
    input  comp_t            mac_out_i,
    output logic             busy_o,
    output logic             inference_complete_o
);

    cim_state_t state_q;
    // Sample index during load, embedding row during projection
    logic [$clog2(PATCH_LEN)-1:0] row_q;
    logic [$clog2(NUM_PATCHES)-1:0] patch_q;
    logic launch_q;
    logic last_wr_q;
    logic epoch_start;
    logic load_start;

    assign epoch_start = new_sleep_epoch_i & (state_q == IDLE_CIM || state_q == EEG_LOAD);
    assign load_start = start_eeg_load_i & ~new_sleep_epoch_i & (state_q == IDLE_CIM);
    assign mac_len_o = vec_len_t'(PATCH_LEN);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE_CIM;
            busy_o <= 1'b0;
            inference_complete_o <= 1'b0;
        end else begin
            inference_complete_o <= 1'b0;
            unique case (state_q)
                IDLE_CIM, EEG_LOAD: begin
                    if (epoch_start) begin
                        state_q <= INFERENCE_RUNNING;
                        busy_o <= 1'b1;
                    end else if (load_start) begin
                        state_q <= EEG_LOAD;
                    end
                end
                INFERENCE_RUNNING: begin
                    // Last result is being written this cycle
                    if (last_wr_q) begin
                        state_q <= IDLE_CIM;
                        busy_o <= 1'b0;
                        inference_complete_o <= 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE_CIM;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_q <= '0;
            patch_q <= '0;
            launch_q <= 1'b0;
            last_wr_q <= 1'b0;
            mac_start_o <= 1'b0;
            wr_en_o <= 1'b0;
        end else begin
            mac_start_o <= 1'b0;
            wr_en_o <= 1'b0;
            last_wr_q <= 1'b0;
            if (epoch_start || load_start) begin
                row_q <= '0;
                patch_q <= '0;
                launch_q <= epoch_start;
            end else if (state_q == EEG_LOAD && new_eeg_data_i) begin
                wr_en_o <= 1'b1;
                wr_addr_o <= int_res_addr_t'(EEG_BASE + PATCH_LEN * int'(patch_q) + int'(row_q));
                // Normalize to [0, 1) in the compute format
                wr_data_o <= comp_t'({eeg_i, {(COMP_Q - ADC_W){1'b0}}});
                if (int'(row_q) == PATCH_LEN - 1) begin
                    row_q <= '0;
                    if (int'(patch_q) == NUM_PATCHES - 1) begin
                        patch_q <= '0;
                    end else begin
                        patch_q <= patch_q + 1'b1;
                    end
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end else if (state_q == INFERENCE_RUNNING) begin
                if (launch_q) begin
                    launch_q <= 1'b0;
                    mac_start_o <= 1'b1;
                    mac_data_addr_o <= int_res_addr_t'(EEG_BASE + PATCH_LEN * int'(patch_q));
                    mac_kernel_addr_o <= param_addr_t'(KERNEL_BASE + PATCH_LEN * int'(row_q));
                    mac_bias_addr_o <= param_addr_t'(BIAS_BASE + int'(row_q));
                end
                if (mac_done_i) begin
                    wr_en_o <= 1'b1;
                    wr_addr_o <= int_res_addr_t'(PATCH_OUT_BASE + EMB_DEPTH * int'(patch_q)
                                                 + int'(row_q));
                    wr_data_o <= mac_out_i;
                    if (int'(row_q) == EMB_DEPTH - 1) begin
                        row_q <= '0;
                        if (int'(patch_q) == NUM_PATCHES - 1) begin
                            patch_q <= '0;
                            last_wr_q <= 1'b1;
                        end else begin
                            patch_q <= patch_q + 1'b1;
                            launch_q <= 1'b1;
                        end
                    end else begin
                        row_q <= row_q + 1'b1;
                        launch_q <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: cim_top.sv
`timescale 1ns/1ps

module cim_top
    import fx_pkg::*, model_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_eeg_load_i,
    input  logic             new_eeg_data_i,
    input  logic [ADC_W-1:0] eeg_i,
    input  logic             new_sleep_epoch_i,
    input  logic             param_wr_en_i,
    input  param_addr_t      param_wr_addr_i,
    input  param_t           param_wr_data_i,
    input  logic             host_rd_en_i,
    input  int_res_addr_t    host_rd_addr_i,
    output comp_t            host_rd_data_o,
    output logic             busy_o,
    output logic             inference_complete_o
);

    logic          int_res_wr_en;
    int_res_addr_t int_res_wr_addr;
    comp_t         int_res_wr_data;
    logic          int_res_rd_en;
    int_res_addr_t int_res_rd_addr;
    comp_t         int_res_rd_data;
    logic          param_rd_en;
    param_addr_t   param_rd_addr;
    param_t        param_rd_data;
    logic          mac_start;
    int_res_addr_t mac_data_addr;
    param_addr_t   mac_kernel_addr;
    param_addr_t   mac_bias_addr;
    vec_len_t      mac_len;
    logic          mac_done;
    comp_t         mac_out;

    assign host_rd_data_o = int_res_rd_data;

    cim_ctrl u_ctrl (
        .clk                 (clk),
        .rst_n               (rst_n),
        .start_eeg_load_i    (start_eeg_load_i),
        .new_eeg_data_i      (new_eeg_data_i),
        .eeg_i               (eeg_i),
        .new_sleep_epoch_i   (new_sleep_epoch_i),
        .wr_en_o             (int_res_wr_en),
        .wr_addr_o           (int_res_wr_addr),
        .wr_data_o           (int_res_wr_data),
        .mac_start_o         (mac_start),
        .mac_data_addr_o     (mac_data_addr),
        .mac_kernel_addr_o   (mac_kernel_addr),
        .mac_bias_addr_o     (mac_bias_addr),
        .mac_len_o           (mac_len),
        .mac_done_i          (mac_done),
        .mac_out_i           (mac_out),
        .busy_o              (busy_o),
        .inference_complete_o(inference_complete_o)
    );

    mac_unit u_mac (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (mac_start),
        .data_addr_i    (mac_data_addr),
        .kernel_addr_i  (mac_kernel_addr),
        .bias_addr_i    (mac_bias_addr),
        .len_i          (mac_len),
        .data_rd_en_o   (int_res_rd_en),
        .data_rd_addr_o (int_res_rd_addr),
        .data_i         (int_res_rd_data),
        .param_rd_en_o  (param_rd_en),
        .param_rd_addr_o(param_rd_addr),
        .param_i        (param_rd_data),
        .done_o         (mac_done),
        .out_o          (mac_out)
    );

    int_res_bank u_int_res (
        .clk           (clk),
        .wr_en_i       (int_res_wr_en),
        .wr_addr_i     (int_res_wr_addr),
        .wr_data_i     (int_res_wr_data),
        .mac_rd_en_i   (int_res_rd_en),
        .mac_rd_addr_i (int_res_rd_addr),
        .host_rd_en_i  (host_rd_en_i),
        .host_rd_addr_i(host_rd_addr_i),
        .rd_data_o     (int_res_rd_data)
    );

    // Only the outside writes parameters
    ram_1r1w #(
        .word_t(param_t),
        .DEPTH (PARAM_DEPTH)
    ) u_param_mem (
        .clk      (clk),
        .wr_en_i  (param_wr_en_i),
        .wr_addr_i(param_wr_addr_i),
        .wr_data_i(param_wr_data_i),
        .rd_en_i  (param_rd_en),
        .rd_addr_i(param_rd_addr),
        .rd_data_o(param_rd_data)
    );

endmodule

// File: tb_cim.sv
`timescale 1ns/1ps

module tb_cim
    import fx_pkg::*, model_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS = 6;
    localparam int EEG_WORDS = NUM_PATCHES * PATCH_LEN;
    localparam int OUT_WORDS = NUM_PATCHES * EMB_DEPTH;
    localparam int KERNEL_WORDS = EMB_DEPTH * PATCH_LEN;
    localparam int PARAM_WORDS = KERNEL_WORDS + EMB_DEPTH;
    localparam int LOAD_CYCLES = 2 * PARAM_WORDS + EEG_WORDS + 2
                                 + 2 * (2 * EEG_WORDS + OUT_WORDS) + 16;
    localparam int RUN_CYCLES = NUM_PATCHES * EMB_DEPTH * (PATCH_LEN + 6);
    localparam longint WATCHDOG_NS = 2 * NUM_TESTS * (LOAD_CYCLES + RUN_CYCLES) * CLK_PERIOD;

    localparam int K_RAND = 0;
    localparam int K_ZERO = 1;
    localparam int K_NEG = 2;
    localparam int E_RAND = 0;
    localparam int E_ONES = 1;
    localparam int E_RAMP = 2;

    // Test table
    string test_name [NUM_TESTS] = '{"rand_kernel_rand_eeg", "neg_kernel_ones_eeg",
        "neg_kernel_repeat", "zero_kernel_ramp_eeg", "rand_kernel_ramp_keep",
        "rand_kernel_ones_eeg"};
    int kernel_mode [NUM_TESTS] = '{K_RAND, K_NEG, K_NEG, K_ZERO, K_RAND, K_RAND};
    int eeg_mode [NUM_TESTS] = '{E_RAND, E_ONES, E_ONES, E_RAMP, E_RAMP, E_ONES};
    bit eeg_reload [NUM_TESTS] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};

    logic             clk;
    logic             rst_n;
    logic             start_eeg_load_i;
    logic             new_eeg_data_i;
    logic [ADC_W-1:0] eeg_i;
    logic             new_sleep_epoch_i;
    logic             param_wr_en_i;
    param_addr_t      param_wr_addr_i;
    param_t           param_wr_data_i;
    logic             host_rd_en_i;
    int_res_addr_t    host_rd_addr_i;
    comp_t            host_rd_data_o;
    logic             busy_o;
    logic             inference_complete_o;

    // Reference copies of what the DUT should hold
    logic [ADC_W-1:0] eeg_model [EEG_WORDS];
    param_t           param_model [PARAM_DEPTH];
    comp_t            expect_out [OUT_WORDS];
    comp_t            prev_out [OUT_WORDS];

    cim_top u_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .start_eeg_load_i    (start_eeg_load_i),
        .new_eeg_data_i      (new_eeg_data_i),
        .eeg_i               (eeg_i),
        .new_sleep_epoch_i   (new_sleep_epoch_i),
        .param_wr_en_i       (param_wr_en_i),
        .param_wr_addr_i     (param_wr_addr_i),
        .param_wr_data_i     (param_wr_data_i),
        .host_rd_en_i        (host_rd_en_i),
        .host_rd_addr_i      (host_rd_addr_i),
        .host_rd_data_o      (host_rd_data_o),
        .busy_o              (busy_o),
        .inference_complete_o(inference_complete_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the DUT did not finish the tests in time");
        $display("Done: errors found");
        $fatal(1);
    end

    task automatic check_value(input string name, input int addr, input comp_t exp,
                               input comp_t act);
        assert (exp === act) else begin
            $display("[FAIL] %s addr %0d expected %h actual %h", name, addr, exp, act);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input bit cond, input string what);
        assert (cond) else begin
            $display("%s: %s", name, what);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    function automatic param_t param_value(input int mode, input int addr);
        if (mode == K_RAND) begin
            return param_t'($urandom);
        end else if (mode == K_NEG) begin
            return param_t'(addr * 7 - 32768);
        end
        // Zero kernel with an address-dependent bias
        if (addr < BIAS_BASE) begin
            return '0;
        end
        return param_t'(addr * 321 - 9000);
    endfunction

    function automatic logic [ADC_W-1:0] eeg_value(input int mode, input int idx);
        if (mode == E_RAND) begin
            return ADC_W'($urandom);
        end else if (mode == E_ONES) begin
            return '1;
        end
        return ADC_W'(idx * 97 + 5);
    endfunction

    // Fixed-point dot product plus bias with COMP_W wrap
    function automatic comp_t ref_dot(input int patch, input int row);
        logic [COMP_W-1:0] acc;
        longint d;
        longint pc;
        longint prod;
        acc = '0;
        for (int k = 0; k < PATCH_LEN; k++) begin
            d = longint'(eeg_model[patch * PATCH_LEN + k]) << (COMP_Q - ADC_W);
            pc = longint'(param_model[KERNEL_BASE + row * PATCH_LEN + k])
                 * (longint'(1) << (COMP_Q - PARAM_Q));
            prod = (d * pc) >>> COMP_Q;
            acc = acc + prod[COMP_W-1:0];
        end
        pc = longint'(param_model[BIAS_BASE + row]) * (longint'(1) << (COMP_Q - PARAM_Q));
        acc = acc + pc[COMP_W-1:0];
        return comp_t'(acc);
    endfunction

    task automatic load_params(input int mode);
        int a;
        int addr;
        for (a = 0; a < PARAM_WORDS; a++) begin
            if (a < KERNEL_WORDS) begin
                addr = KERNEL_BASE + a;
            end else begin
                addr = BIAS_BASE + a - KERNEL_WORDS;
            end
            param_model[addr] = param_value(mode, addr);
            @(negedge clk);
            param_wr_en_i = 1'b1;
            param_wr_addr_i = param_addr_t'(addr);
            param_wr_data_i = param_model[addr];
        end
        @(negedge clk);
        param_wr_en_i = 1'b0;
    endtask

    task automatic load_eeg(input int mode);
        int i;
        @(negedge clk);
        start_eeg_load_i = 1'b1;
        @(negedge clk);
        start_eeg_load_i = 1'b0;
        for (i = 0; i < EEG_WORDS; i++) begin
            eeg_model[i] = eeg_value(mode, i);
            eeg_i = eeg_model[i];
            new_eeg_data_i = 1'b1;
            @(negedge clk);
        end
        new_eeg_data_i = 1'b0;
    endtask

    task automatic read_word(input int addr, output comp_t data);
        @(negedge clk);
        host_rd_en_i = 1'b1;
        host_rd_addr_i = int_res_addr_t'(addr);
        @(negedge clk);
        host_rd_en_i = 1'b0;
        data = host_rd_data_o;
    endtask

    task automatic check_eeg_region(input string name);
        comp_t data;
        for (int i = 0; i < EEG_WORDS; i++) begin
            read_word(EEG_BASE + i, data);
            check_value(name, EEG_BASE + i,
                        comp_t'(int'(eeg_model[i]) << (COMP_Q - ADC_W)), data);
        end
    endtask

    task automatic run_inference(input string name);
        @(negedge clk);
        new_sleep_epoch_i = 1'b1;
        @(negedge clk);
        new_sleep_epoch_i = 1'b0;
        check_flag(name, busy_o === 1'b1, "busy_o did not rise after new_sleep_epoch_i");
        // EEG strobes while busy must be ignored
        while (inference_complete_o !== 1'b1) begin
            new_eeg_data_i = 1'b1;
            eeg_i = ADC_W'($urandom);
            @(negedge clk);
        end
        new_eeg_data_i = 1'b0;
        check_flag(name, busy_o === 1'b0, "busy_o still high at inference_complete_o");
        repeat (4) begin
            @(negedge clk);
            check_flag(name, inference_complete_o === 1'b0,
                       "inference_complete_o pulsed more than once");
            check_flag(name, busy_o === 1'b0, "busy_o rose again after the run");
        end
    endtask

    task automatic check_outputs(input string name, input bit same_as_prev);
        comp_t data;
        int a;
        for (int i = 0; i < OUT_WORDS; i++) begin
            a = PATCH_OUT_BASE + i;
            read_word(a, data);
            check_value(name, a, expect_out[i], data);
            if (same_as_prev) begin
                check_value(name, a, prev_out[i], data);
            end
            prev_out[i] = data;
        end
    endtask

    initial begin
        bit repeat_run;
        void'($urandom(32'hb621));
        rst_n = 1'b0;
        start_eeg_load_i = 1'b0;
        new_eeg_data_i = 1'b0;
        eeg_i = '0;
        new_sleep_epoch_i = 1'b0;
        param_wr_en_i = 1'b0;
        param_wr_addr_i = '0;
        param_wr_data_i = '0;
        host_rd_en_i = 1'b0;
        host_rd_addr_i = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        repeat (5) begin
            @(negedge clk);
            check_flag("reset", busy_o === 1'b0, "busy_o is not low after reset");
            check_flag("reset", inference_complete_o === 1'b0,
                       "inference_complete_o is not low after reset");
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            repeat_run = 1'b0;
            if (t > 0) begin
                repeat_run = !eeg_reload[t] && kernel_mode[t] == kernel_mode[t-1]
                             && kernel_mode[t] != K_RAND;
            end
            load_params(kernel_mode[t]);
            if (eeg_reload[t]) begin
                load_eeg(eeg_mode[t]);
                check_eeg_region(test_name[t]);
            end
            for (int p = 0; p < NUM_PATCHES; p++) begin
                for (int r = 0; r < EMB_DEPTH; r++) begin
                    expect_out[p * EMB_DEPTH + r] = ref_dot(p, r);
                end
            end
            run_inference(test_name[t]);
            check_eeg_region(test_name[t]);
            check_outputs(test_name[t], repeat_run);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: build.f
fx_pkg.sv
model_pkg.sv
ram_1r1w.sv
int_res_bank.sv
mac_unit.sv
cim_ctrl.sv
cim_top.sv
tb_cim.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cim -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_cim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Done: no errors"; then
    exit 0
fi
exit 1
